//--- raster_pkg.sv
// shared definitions for the triangle rasterizer
// screen and buffer sizes, pixel color fields
// coefficient, edge value and address types, walker states

`default_nettype none

package raster_pkg;

  ////////////////////
  // frame buffer geometry
  ////////////////////
  // half of the 640x480 display in each direction
  localparam int fb_width  = 320;
  localparam int fb_height = 240;
  localparam int fb_depth  = fb_width * fb_height;

  // screen coordinates
  typedef logic [8:0] coord_x_t;
  typedef logic [7:0] coord_y_t;

  // linear buffer address, row * 320 + column
  typedef logic [16:0] fb_addr_t;

  ////////////////////
  // pixel color
  ////////////////////
  // 3-3-2 packing, rrrgggbb
  typedef logic [7:0] color_t;
  localparam int red_msb   = 7;
  localparam int green_msb = 4;
  localparam int blue_msb  = 1;

  ////////////////////
  // edge equations
  ////////////////////
  // a and b span at most one screen dimension
  typedef logic signed [9:0] coef_t;
  // c is a difference of two 17-bit products
  typedef logic signed [18:0] const_t;
  // a*x + b*y + c with headroom
  typedef logic signed [20:0] edge_sum_t;

  // setup cycles from start to done
  localparam int edge_latency = 2;

  // walker sequencing
  typedef enum logic [1:0] {
    walk_idle,
    walk_setup,
    walk_scan
  } walk_state_t;

endpackage

`default_nettype wire

//--- edge_setup.sv
// edge equation and bounding box setup
// two pipeline stages, each loaded by the strobe passing through it
// outputs hold until the next triangle reaches stage two

`default_nettype none

module edge_setup
  import raster_pkg::*;
(
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  logic      edge_start,
  input  coord_x_t  v1x,
  input  coord_x_t  v2x,
  input  coord_x_t  v3x,
  input  coord_y_t  v1y,
  input  coord_y_t  v2y,
  input  coord_y_t  v3y,
  input  color_t    tri_color,
  output logic      edge_done,
  output coef_t     a1,
  output coef_t     b1,
  output coef_t     a2,
  output coef_t     b2,
  output coef_t     a3,
  output coef_t     b3,
  output const_t    c1,
  output const_t    c2,
  output const_t    c3,
  output coord_x_t  bb_x_min,
  output coord_x_t  bb_x_max,
  output coord_y_t  bb_y_min,
  output coord_y_t  bb_y_max,
  output color_t    edge_color
);

  // strobe shift, one bit per stage
  logic [edge_latency-1:0] start_pipe;

  // stage one results
  coef_t       da1, db1, da2, db2, da3, db3;
  logic [16:0] p12, p21, p23, p32, p31, p13;
  coord_x_t    x_lo, x_hi, x3_s1;
  coord_y_t    y_lo, y_hi, y3_s1;
  color_t      color_s1;

  assign edge_done = start_pipe[edge_latency-1];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      start_pipe <= '0;
    end else begin
      start_pipe <= {start_pipe[edge_latency-2:0], edge_start};
    end
  end

  ////////////////////
  // stage one
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (edge_start) begin
      // edges run 1->2, 2->3, 3->1
      da1 <= coef_t'(v1y) - coef_t'(v2y);
      db1 <= coef_t'(v2x) - coef_t'(v1x);
      da2 <= coef_t'(v2y) - coef_t'(v3y);
      db2 <= coef_t'(v3x) - coef_t'(v2x);
      da3 <= coef_t'(v3y) - coef_t'(v1y);
      db3 <= coef_t'(v1x) - coef_t'(v3x);
      // cross products for c, all unsigned here
      p12 <= v1x * v2y;
      p21 <= v2x * v1y;
      p23 <= v2x * v3y;
      p32 <= v3x * v2y;
      p31 <= v3x * v1y;
      p13 <= v1x * v3y;
      // first pair of the box compare
      x_lo     <= (v1x < v2x) ? v1x : v2x;
      x_hi     <= (v1x < v2x) ? v2x : v1x;
      y_lo     <= (v1y < v2y) ? v1y : v2y;
      y_hi     <= (v1y < v2y) ? v2y : v1y;
      x3_s1    <= v3x;
      y3_s1    <= v3y;
      color_s1 <= tri_color;
    end
  end

  ////////////////////
  // stage two
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (start_pipe[0]) begin
      a1 <= da1;
      b1 <= db1;
      a2 <= da2;
      b2 <= db2;
      a3 <= da3;
      b3 <= db3;
      c1 <= const_t'(p12) - const_t'(p21);
      c2 <= const_t'(p23) - const_t'(p32);
      c3 <= const_t'(p31) - const_t'(p13);
      // third vertex against the pair
      bb_x_min   <= (x3_s1 < x_lo) ? x3_s1 : x_lo;
      bb_x_max   <= (x3_s1 > x_hi) ? x3_s1 : x_hi;
      bb_y_min   <= (y3_s1 < y_lo) ? y3_s1 : y_lo;
      bb_y_max   <= (y3_s1 > y_hi) ? y3_s1 : y_hi;
      edge_color <= color_s1;
    end
  end

endmodule

`default_nettype wire

//--- raster_walk.sv
// triangle acceptance and bounding box walk
// FSM takes one triangle at a time and starts setup
// edge sums are stepped by a per column and b per row

`default_nettype none

module raster_walk
  import raster_pkg::*;
(
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  logic      tri_valid,
  input  coord_x_t  v1x,
  input  coord_x_t  v2x,
  input  coord_x_t  v3x,
  input  coord_y_t  v1y,
  input  coord_y_t  v2y,
  input  coord_y_t  v3y,
  input  color_t    color,
  input  logic      edge_done,
  input  coef_t     a1,
  input  coef_t     b1,
  input  coef_t     a2,
  input  coef_t     b2,
  input  coef_t     a3,
  input  coef_t     b3,
  input  const_t    c1,
  input  const_t    c2,
  input  const_t    c3,
  input  coord_x_t  bb_x_min,
  input  coord_x_t  bb_x_max,
  input  coord_y_t  bb_y_min,
  input  coord_y_t  bb_y_max,
  input  color_t    edge_color,
  output logic      tri_ready,
  output logic      edge_start,
  output coord_x_t  tri_x1,
  output coord_x_t  tri_x2,
  output coord_x_t  tri_x3,
  output coord_y_t  tri_y1,
  output coord_y_t  tri_y2,
  output coord_y_t  tri_y3,
  output color_t    tri_color,
  output logic      wr_en,
  output fb_addr_t  wr_addr,
  output color_t    wr_data
);

  walk_state_t state;

  // running sums and their row-start copies
  edge_sum_t sum1, sum2, sum3;
  edge_sum_t row1, row2, row3;
  edge_sum_t nxt_row1, nxt_row2, nxt_row3;
  edge_sum_t start1, start2, start3;
  fb_addr_t  row_addr, start_addr;
  coord_x_t  cur_x;
  coord_y_t  cur_y;

  logic accept;
  logic row_end;
  logic last_pixel;
  logic covered;

  // edge value at one pixel, only used once per triangle
  function automatic edge_sum_t edge_at(coef_t a, coef_t b, const_t c,
                                        coord_x_t x, coord_y_t y);
    edge_sum_t ax;
    edge_sum_t by;
    ax = edge_sum_t'(a) * edge_sum_t'(x);
    by = edge_sum_t'(b) * edge_sum_t'(y);
    return ax + by + edge_sum_t'(c);
  endfunction

  assign accept     = tri_valid && tri_ready;
  assign row_end    = (cur_x == bb_x_max);
  assign last_pixel = row_end && (cur_y == bb_y_max);

  // top left corner of the box
  assign start1     = edge_at(a1, b1, c1, bb_x_min, bb_y_min);
  assign start2     = edge_at(a2, b2, c2, bb_x_min, bb_y_min);
  assign start3     = edge_at(a3, b3, c3, bb_x_min, bb_y_min);
  assign start_addr = fb_addr_t'(bb_y_min) * fb_addr_t'(fb_width) + fb_addr_t'(bb_x_min);

  assign nxt_row1 = row1 + edge_sum_t'(b1);
  assign nxt_row2 = row2 + edge_sum_t'(b2);
  assign nxt_row3 = row3 + edge_sum_t'(b3);

  // inside for either winding, edges count as inside
  assign covered = ((sum1 >= 0) && (sum2 >= 0) && (sum3 >= 0)) ||
                   ((sum1 <= 0) && (sum2 <= 0) && (sum3 <= 0));

  assign wr_en   = (state == walk_scan) && covered;
  // setup holds the color for the whole walk
  assign wr_data = edge_color;

  ////////////////////
  // sequencing
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state      <= walk_idle;
      tri_ready  <= 1'b1;
      edge_start <= 1'b0;
    end else begin
      edge_start <= 1'b0;
      case (state)
        walk_idle: begin
          if (accept) begin
            state      <= walk_setup;
            tri_ready  <= 1'b0;
            edge_start <= 1'b1;
          end
        end
        walk_setup: begin
          if (edge_done) begin
            state <= walk_scan;
          end
        end
        walk_scan: begin
          // done after the bottom right pixel
          if (last_pixel) begin
            state     <= walk_idle;
            tri_ready <= 1'b1;
          end
        end
        default: begin
          state <= walk_idle;
        end
      endcase
    end
  end

  ////////////////////
  // datapath
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (accept) begin
      tri_x1    <= v1x;
      tri_x2    <= v2x;
      tri_x3    <= v3x;
      tri_y1    <= v1y;
      tri_y2    <= v2y;
      tri_y3    <= v3y;
      tri_color <= color;
    end
    if (state == walk_setup && edge_done) begin
      sum1     <= start1;
      sum2     <= start2;
      sum3     <= start3;
      row1     <= start1;
      row2     <= start2;
      row3     <= start3;
      wr_addr  <= start_addr;
      row_addr <= start_addr;
      cur_x    <= bb_x_min;
      cur_y    <= bb_y_min;
    end else if (state == walk_scan) begin
      if (row_end) begin
        // restart from the row copy one line down
        sum1     <= nxt_row1;
        sum2     <= nxt_row2;
        sum3     <= nxt_row3;
        row1     <= nxt_row1;
        row2     <= nxt_row2;
        row3     <= nxt_row3;
        wr_addr  <= row_addr + fb_addr_t'(fb_width);
        row_addr <= row_addr + fb_addr_t'(fb_width);
        cur_x    <= bb_x_min;
        cur_y    <= cur_y + 1'b1;
      end else begin
        sum1    <= sum1 + edge_sum_t'(a1);
        sum2    <= sum2 + edge_sum_t'(a2);
        sum3    <= sum3 + edge_sum_t'(a3);
        wr_addr <= wr_addr + 1'b1;
        cur_x   <= cur_x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- frame_buffer.sv
// frame buffer, one byte per pixel
// write port for the walker, registered read port for scan-out

`default_nettype none

module frame_buffer
  import raster_pkg::*;
(
  input  logic      S_AXI_ACLK,
  input  logic      wr_en,
  input  fb_addr_t  wr_addr,
  input  color_t    wr_data,
  input  fb_addr_t  rd_addr,
  output color_t    rd_data
);

  // maps onto block RAM
  color_t mem [0:fb_depth-1];

  // write side
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read side, old data on a same-edge collision
  always_ff @(posedge S_AXI_ACLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- scan_out.sv
// display read-out
// 640x480 position to half-resolution buffer address
// 3-3-2 pixel widened to 4-bit channels

`default_nettype none

module scan_out
  import raster_pkg::*;
(
  input  logic        S_AXI_ACLK,
  input  logic        S_AXI_ARESETN,
  input  logic [9:0]  draw_x,
  input  logic [9:0]  draw_y,
  input  color_t      rd_data,
  output fb_addr_t    rd_addr,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue
);

  // each buffer pixel covers a 2x2 display block
  assign rd_addr = fb_addr_t'(draw_y[9:1]) * fb_addr_t'(fb_width) + fb_addr_t'(draw_x[9:1]);

  ////////////////////
  // color expansion
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      red   <= 4'd0;
      green <= 4'd0;
      blue  <= 4'd0;
    end else begin
      // low bits padded with zero
      red   <= {rd_data[red_msb -: 3], 1'b0};
      green <= {rd_data[green_msb -: 3], 1'b0};
      blue  <= {rd_data[blue_msb -: 2], 2'b00};
    end
  end

endmodule

`default_nettype wire

//--- raster_top.sv
// rasterizer top level
// setup and walker draw into the frame buffer
// scan-out reads it back for the display

`default_nettype none

module raster_top
  import raster_pkg::*;
(
  input  logic        S_AXI_ACLK,
  input  logic        S_AXI_ARESETN,
  input  logic        tri_valid,
  input  coord_x_t    v1x,
  input  coord_x_t    v2x,
  input  coord_x_t    v3x,
  input  coord_y_t    v1y,
  input  coord_y_t    v2y,
  input  coord_y_t    v3y,
  input  color_t      color,
  input  logic [9:0]  draw_x,
  input  logic [9:0]  draw_y,
  output logic        tri_ready,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue
);

  // walker to setup
  logic      edge_start;
  logic      edge_done;
  coord_x_t  tri_x1, tri_x2, tri_x3;
  coord_y_t  tri_y1, tri_y2, tri_y3;
  color_t    tri_color;

  // setup results
  coef_t     a1, b1, a2, b2, a3, b3;
  const_t    c1, c2, c3;
  coord_x_t  bb_x_min, bb_x_max;
  coord_y_t  bb_y_min, bb_y_max;
  color_t    edge_color;

  // buffer ports
  logic      wr_en;
  fb_addr_t  wr_addr;
  color_t    wr_data;
  fb_addr_t  rd_addr;
  color_t    rd_data;

  ////////////////////
  // producer
  ////////////////////
  edge_setup u_edge_setup (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .edge_start    (edge_start),
    .v1x           (tri_x1),
    .v2x           (tri_x2),
    .v3x           (tri_x3),
    .v1y           (tri_y1),
    .v2y           (tri_y2),
    .v3y           (tri_y3),
    .tri_color     (tri_color),
    .edge_done     (edge_done),
    .a1            (a1),
    .b1            (b1),
    .a2            (a2),
    .b2            (b2),
    .a3            (a3),
    .b3            (b3),
    .c1            (c1),
    .c2            (c2),
    .c3            (c3),
    .bb_x_min      (bb_x_min),
    .bb_x_max      (bb_x_max),
    .bb_y_min      (bb_y_min),
    .bb_y_max      (bb_y_max),
    .edge_color    (edge_color)
  );

  // host vertices enter here
  raster_walk u_raster_walk (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .tri_valid     (tri_valid),
    .v1x           (v1x),
    .v2x           (v2x),
    .v3x           (v3x),
    .v1y           (v1y),
    .v2y           (v2y),
    .v3y           (v3y),
    .color         (color),
    .edge_done     (edge_done),
    .a1            (a1),
    .b1            (b1),
    .a2            (a2),
    .b2            (b2),
    .a3            (a3),
    .b3            (b3),
    .c1            (c1),
    .c2            (c2),
    .c3            (c3),
    .bb_x_min      (bb_x_min),
    .bb_x_max      (bb_x_max),
    .bb_y_min      (bb_y_min),
    .bb_y_max      (bb_y_max),
    .edge_color    (edge_color),
    .tri_ready     (tri_ready),
    .edge_start    (edge_start),
    .tri_x1        (tri_x1),
    .tri_x2        (tri_x2),
    .tri_x3        (tri_x3),
    .tri_y1        (tri_y1),
    .tri_y2        (tri_y2),
    .tri_y3        (tri_y3),
    .tri_color     (tri_color),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  ////////////////////
  // buffer and consumer
  ////////////////////
  frame_buffer u_frame_buffer (
    .S_AXI_ACLK (S_AXI_ACLK),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  scan_out u_scan_out (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .draw_x        (draw_x),
    .draw_y        (draw_y),
    .rd_data       (rd_data),
    .rd_addr       (rd_addr),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source
// 10 unit period, reset low over the first two rising edges

`default_nettype none

module tb_clock_gen (
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // release just after the second edge
  initial begin
    S_AXI_ARESETN = 1'b0;
    repeat (2) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_raster_top.sv
// testbench for the triangle rasterizer
// drives triangles and keeps a pixel model of the buffer
// reads back through scan-out
// watchdog bounds the run

`default_nettype none

module tb_raster_top
  import raster_pkg::*;
();

  localparam int clk_period = 10;
  localparam int walk_max   = fb_depth + 4;
  localparam int draw_limit = fb_depth + 16;
  localparam int read_max   = 20000;
  // two full-screen walks and forty more plus reads of three cycles, all doubled
  localparam int watchdog_time = ((2 + 40) * walk_max + 3 * read_max) * 2 * clk_period;

  localparam color_t bg_color    = 8'h6d;
  localparam color_t stray_color = 8'h5a;
  // stray triangle strobed while busy
  localparam int sx1 = 150;
  localparam int sy1 = 100;
  localparam int sx2 = 250;
  localparam int sy2 = 110;
  localparam int sx3 = 200;
  localparam int sy3 = 200;

  logic       S_AXI_ACLK;
  logic       S_AXI_ARESETN;
  logic       tri_valid;
  coord_x_t   v1x, v2x, v3x;
  coord_y_t   v1y, v2y, v3y;
  color_t     color;
  logic [9:0] draw_x;
  logic [9:0] draw_y;
  logic       tri_ready;
  logic [3:0] red, green, blue;

  // expected buffer indexed by row * 320 + column
  color_t model [0:fb_depth-1];

  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int unsigned seed;

  tb_clock_gen u_clock_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN)
  );

  raster_top u_raster_top (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .tri_valid     (tri_valid),
    .v1x           (v1x),
    .v2x           (v2x),
    .v3x           (v3x),
    .v1y           (v1y),
    .v2y           (v2y),
    .v3y           (v3y),
    .color         (color),
    .draw_x        (draw_x),
    .draw_y        (draw_y),
    .tri_ready     (tri_ready),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  ////////////////////
  // reference model
  ////////////////////
  function automatic int min3(int p, int q, int r);
    int m;
    m = (p < q) ? p : q;
    return (r < m) ? r : m;
  endfunction

  function automatic int max3(int p, int q, int r);
    int m;
    m = (p > q) ? p : q;
    return (r > m) ? r : m;
  endfunction

  function automatic int clamp(int v, int hi);
    if (v < 0) return 0;
    if (v > hi) return hi;
    return v;
  endfunction

  // edges 1->2, 2->3 and 3->1 in either winding
  function automatic bit covers(int x1, int y1, int x2, int y2, int x3, int y3,
                                int px, int py);
    int e1;
    int e2;
    int e3;
    e1 = (y1 - y2) * px + (x2 - x1) * py + (x1 * y2 - x2 * y1);
    e2 = (y2 - y3) * px + (x3 - x2) * py + (x2 * y3 - x3 * y2);
    e3 = (y3 - y1) * px + (x1 - x3) * py + (x3 * y1 - x1 * y3);
    return ((e1 >= 0) && (e2 >= 0) && (e3 >= 0)) ||
           ((e1 <= 0) && (e2 <= 0) && (e3 <= 0));
  endfunction

  task automatic model_draw(input int x1, y1, x2, y2, x3, y3, input color_t c);
    for (int y = min3(y1, y2, y3); y <= max3(y1, y2, y3); y++) begin
      for (int x = min3(x1, x2, x3); x <= max3(x1, x2, x3); x++) begin
        if (covers(x1, y1, x2, y2, x3, y3, x, y)) begin
          model[y * fb_width + x] = c;
        end
      end
    end
  endtask

  // model value behind a display position
  function automatic color_t model_at(int dx, int dy);
    return model[(dy / 2) * fb_width + dx / 2];
  endfunction

  ////////////////////
  // host side
  ////////////////////
  // optional stray strobe on the fifth busy cycle
  task automatic draw_triangle(input int x1, y1, x2, y2, x3, y3, input color_t c,
                               input bit stray);
    int busy;
    int expected;
    expected = 3 + (max3(x1, x2, x3) - min3(x1, x2, x3) + 1) *
                   (max3(y1, y2, y3) - min3(y1, y2, y3) + 1);
    checks++;
    assert (tri_ready === 1'b1) else begin
      errors++;
      $display("mismatch at %0t: tri_ready low before a new triangle", $time);
    end
    v1x       = coord_x_t'(x1);
    v1y       = coord_y_t'(y1);
    v2x       = coord_x_t'(x2);
    v2y       = coord_y_t'(y2);
    v3x       = coord_x_t'(x3);
    v3y       = coord_y_t'(y3);
    color     = c;
    tri_valid = 1'b1;
    @(posedge S_AXI_ACLK);
    #1;
    tri_valid = 1'b0;
    busy      = 0;
    while (tri_ready !== 1'b1 && busy < draw_limit) begin
      if (stray && busy == 4) begin
        v1x       = coord_x_t'(sx1);
        v1y       = coord_y_t'(sy1);
        v2x       = coord_x_t'(sx2);
        v2y       = coord_y_t'(sy2);
        v3x       = coord_x_t'(sx3);
        v3y       = coord_y_t'(sy3);
        color     = stray_color;
        tri_valid = 1'b1;
      end else begin
        tri_valid = 1'b0;
      end
      busy++;
      @(posedge S_AXI_ACLK);
      #1;
    end
    tri_valid = 1'b0;
    model_draw(x1, y1, x2, y2, x3, y3, c);
    if (busy >= draw_limit) begin
      errors++;
      $display("tri_ready never came back after triangle (%0d,%0d) (%0d,%0d) (%0d,%0d)",
               x1, y1, x2, y2, x3, y3);
    end else begin
      checks++;
      assert (busy == expected) else begin
        errors++;
        $display("mismatch at %0t: busy for %0d cycles, expected %0d", $time, busy, expected);
      end
    end
  endtask

  // one display read takes two edges to the color outputs
  task automatic read_check(input int dx, dy, input color_t expect_c, input string what);
    logic [3:0] exp_r;
    logic [3:0] exp_g;
    logic [3:0] exp_b;
    draw_x = 10'(dx);
    draw_y = 10'(dy);
    repeat (2) @(posedge S_AXI_ACLK);
    #1;
    // 3-3-2 fields with padded low bits
    exp_r = {expect_c[7:5], 1'b0};
    exp_g = {expect_c[4:2], 1'b0};
    exp_b = {expect_c[1:0], 2'b00};
    checks++;
    assert (red === exp_r && green === exp_g && blue === exp_b) else begin
      errors++;
      $display("mismatch at %0t: %s at (%0d,%0d) rgb %h %h %h, expected %h %h %h",
               $time, what, dx, dy, red, green, blue, exp_r, exp_g, exp_b);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin : stimulus
    int px;
    int py;
    int cx;
    int cy;
    int area;
    int tmp;
    int tx [0:2];
    int ty [0:2];
    color_t c;
    logic [2:0] fr;
    logic [2:0] fg;
    logic [1:0] fb;

    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    tri_valid   = 1'b0;
    v1x         = '0;
    v2x         = '0;
    v3x         = '0;
    v1y         = '0;
    v2y         = '0;
    v3y         = '0;
    color       = '0;
    draw_x      = '0;
    draw_y      = '0;
    seed        = 32'hff2faab9;
    void'($urandom(seed));

    // reset values one time unit past the last reset edge
    wait (S_AXI_ARESETN === 1'b1);
    checks++;
    assert (tri_ready === 1'b1 && red === 4'd0 && green === 4'd0 && blue === 4'd0) else begin
      errors++;
      $display("mismatch at %0t: reset state tri_ready %b rgb %h %h %h",
               $time, tri_ready, red, green, blue);
    end
    end_test("reset state");

    // two halves split on the diagonal
    draw_triangle(0, 0, 319, 0, 319, 239, bg_color, 1'b0);
    draw_triangle(0, 0, 319, 239, 0, 239, bg_color, 1'b0);
    for (int i = 0; i < 200; i++) begin
      if (i < 4) begin
        px = (i % 2) * (fb_width - 1);
        py = (i / 2) * (fb_height - 1);
      end else begin
        px = $urandom % fb_width;
        py = $urandom % fb_height;
      end
      // all four display positions of the pixel
      for (int q = 0; q < 4; q++) begin
        read_check(2 * px + q % 2, 2 * py + q / 2, bg_color, "background");
      end
    end
    end_test("background fill");

    // box plus a 3 pixel margin
    draw_triangle(40, 30, 100, 50, 60, 90, 8'hc3, 1'b0);
    for (int y = 27; y <= 93; y++) begin
      for (int x = 37; x <= 103; x++) begin
        read_check(2 * x, 2 * y, model[y * fb_width + x], "single triangle");
      end
    end
    end_test("single triangle");

    for (int i = 0; i < 30; i++) begin
      if (i == 0) begin
        // degenerate one pixel triangle
        tx[0] = 77;
        tx[1] = 77;
        tx[2] = 77;
        ty[0] = 55;
        ty[1] = 55;
        ty[2] = 55;
      end else if (i == 1) begin
        // zero area with all points on one line
        tx[0] = 10;
        tx[1] = 50;
        tx[2] = 90;
        ty[0] = 10;
        ty[1] = 30;
        ty[2] = 50;
      end else begin
        cx = $urandom % fb_width;
        cy = $urandom % fb_height;
        for (int k = 0; k < 3; k++) begin
          tx[k] = clamp(cx + int'($urandom % 161) - 80, fb_width - 1);
          ty[k] = clamp(cy + int'($urandom % 121) - 60, fb_height - 1);
        end
        area = (tx[1] - tx[0]) * (ty[2] - ty[0]) - (tx[2] - tx[0]) * (ty[1] - ty[0]);
        // even ones one way round and odd ones the other
        if ((i % 2 == 0) != (area >= 0)) begin
          tmp   = tx[1];
          tx[1] = tx[2];
          tx[2] = tmp;
          tmp   = ty[1];
          ty[1] = ty[2];
          ty[2] = tmp;
        end
      end
      c = color_t'($urandom);
      draw_triangle(tx[0], ty[0], tx[1], ty[1], tx[2], ty[2], c, 1'b0);
    end
    for (int i = 0; i < 500; i++) begin
      px = $urandom % 640;
      py = $urandom % 480;
      read_check(px, py, model_at(px, py), "random triangles");
    end
    end_test("random triangles");

    // stray strobe lands mid-walk
    draw_triangle(20, 20, 120, 30, 60, 110, 8'h1c, 1'b1);
    for (int i = 0; i < 300; i++) begin
      px = sx1 + $urandom % (sx2 - sx1 + 1);
      py = sy1 + $urandom % (sy3 - sy1 + 1);
      read_check(2 * px, 2 * py, model[py * fb_width + px], "ignored strobe");
    end
    end_test("ignored strobe");

    // red and green sweep 0..7 while blue runs 0..3 twice
    for (int k = 0; k < 8; k++) begin
      fr = 3'(k);
      fg = 3'(7 - k);
      fb = 2'(k);
      c  = {fr, fg, fb};
      draw_triangle(10 + 30 * k, 200, 30 + 30 * k, 200, 10 + 30 * k, 220, c, 1'b0);
      read_check(2 * (12 + 30 * k), 2 * 202, c, "color expansion");
    end
    end_test("color expansion");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  ////////////////////
  // watchdog
  ////////////////////
  initial begin
    #(watchdog_time);
    $display("timeout: run did not finish within %0d time units", watchdog_time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
raster_pkg.sv
edge_setup.sv
raster_walk.sv
frame_buffer.sv
scan_out.sv
raster_top.sv
tb_clock_gen.sv
tb_raster_top.sv
